//--- common/dviPkg.sv
// Shared constants for the 640x480 at 60 Hz DVI pipeline
// Timing follows the usual 25 MHz pixel clock mode with negative syncs
// Control token bit order is symbol[9:0] as sent LSB first by a serializer

package dviPkg;

    // --------------------------------------------------------------------
    // Horizontal timing in pixels
    // --------------------------------------------------------------------
    localparam int hActive     = 640;
    localparam int hFrontPorch = 16;
    localparam int hSyncLen    = 96;
    localparam int hBackPorch  = 48;
    localparam int hTotal      = hActive + hFrontPorch + hSyncLen + hBackPorch; // 800

    // --------------------------------------------------------------------
    // Vertical timing in lines
    // --------------------------------------------------------------------
    localparam int vActive     = 480;
    localparam int vFrontPorch = 10;
    localparam int vSyncLen    = 2;
    localparam int vBackPorch  = 33;
    localparam int vTotal      = vActive + vFrontPorch + vSyncLen + vBackPorch; // 525

    localparam logic syncActiveLevel = 1'b0; // Both syncs active low
    localparam int   coordWidth      = 10;   // Holds up to 1023

    // --------------------------------------------------------------------
    // Test patterns
    // --------------------------------------------------------------------
    localparam int patWidth   = 2;
    localparam int colorWidth = 8;           // Bits per colour channel

    localparam logic [patWidth-1:0] patColorBars = 2'd0;
    localparam logic [patWidth-1:0] patGradient  = 2'd1;
    localparam logic [patWidth-1:0] patChecker   = 2'd2;
    localparam logic [patWidth-1:0] patSolid     = 2'd3;

    localparam int barWidth     = 80;        // Eight bars across hActive
    localparam int checkerShift = 5;         // 32 pixel squares

    // --------------------------------------------------------------------
    // TMDS symbols
    // --------------------------------------------------------------------
    localparam int tmdsWidth = 10;

    // Indexed as {c1, c0}
    localparam logic [tmdsWidth-1:0] tokenC00 = 10'b1101010100;
    localparam logic [tmdsWidth-1:0] tokenC01 = 10'b0010101011;
    localparam logic [tmdsWidth-1:0] tokenC10 = 10'b0101010100;
    localparam logic [tmdsWidth-1:0] tokenC11 = 10'b1010101011;

endpackage

//--- rtl/resetSync.sv
// Pixel domain reset from system reset and clock manager lock
// locked may be asynchronous and is passed through two flops
// videoRst falls on the 18th consecutive edge sampling rst low and locked high
// Any lock drop raises videoRst right after the second sampling edge
`timescale 1ns/1ps

module resetSync (
    input  logic pixelClk,
    input  logic rst,       // Synchronous, active high
    input  logic locked,    // Lock level from the clock manager
    output logic videoRst   // Active high
);

    logic       lockMeta;   // First sync stage
    logic       lockSync;   // Safe to use
    logic [3:0] stretchCnt;
    logic       holdRst;

    // --------------------------------------------------------------------
    // Lock synchronizer
    // --------------------------------------------------------------------
    always_ff @(posedge pixelClk) begin
        if (rst) begin
            lockMeta <= 1'b0;
            lockSync <= 1'b0;
        end else begin
            lockMeta <= locked;
            lockSync <= lockMeta;
        end
    end

    // Hold for 16 edges of steady lock
    always_ff @(posedge pixelClk) begin
        if (rst || !lockSync) begin
            stretchCnt <= '0;
            holdRst    <= 1'b1;
        end else if (stretchCnt != 4'hF) begin
            stretchCnt <= stretchCnt + 4'd1;
        end else begin
            holdRst    <= 1'b0;                     // Lock stable long enough
        end
    end

    assign videoRst = rst | ~lockSync | holdRst;    // Lock loss acts at once

endmodule

//--- rtl/videoTiming/videoTiming.sv
// Free running 640x480 raster counters with registered decode
// The first edge that samples rst low loads pixel (0,0) onto the outputs
// Under reset de is low, syncs inactive and x, y read zero
// x and y are only meaningful while de is high
`timescale 1ns/1ps

module videoTiming (
    input  logic                          pixelClk,
    input  logic                          rst,
    output logic                          hSync,
    output logic                          vSync,
    output logic                          de,
    output logic                          frameStart,  // One cycle at (0,0)
    output logic [dviPkg::coordWidth-1:0] x,
    output logic [dviPkg::coordWidth-1:0] y
);

    import dviPkg::*;

    logic [coordWidth-1:0] hCnt;   // Position to present next
    logic [coordWidth-1:0] vCnt;
    logic                  hLast;
    logic                  vLast;
    logic                  hSyncWin;
    logic                  vSyncWin;
    logic                  activeWin;

    // --------------------------------------------------------------------
    // Raster counters
    // --------------------------------------------------------------------
    assign hLast = (hCnt == coordWidth'(hTotal - 1));
    assign vLast = (vCnt == coordWidth'(vTotal - 1));

    always_ff @(posedge pixelClk) begin
        if (rst) begin
            hCnt <= '0;
            vCnt <= '0;
        end else if (hLast) begin
            hCnt <= '0;                             // End of line
            if (vLast) begin
                vCnt <= '0;                         // End of frame
            end else begin
                vCnt <= vCnt + 1'b1;
            end
        end else begin
            hCnt <= hCnt + 1'b1;
        end
    end

    // --------------------------------------------------------------------
    // Window decode
    // --------------------------------------------------------------------
    // Sync pulses sit between front and back porch
    assign hSyncWin = (hCnt >= coordWidth'(hActive + hFrontPorch)) &&
                      (hCnt <  coordWidth'(hActive + hFrontPorch + hSyncLen));
    assign vSyncWin = (vCnt >= coordWidth'(vActive + vFrontPorch)) &&
                      (vCnt <  coordWidth'(vActive + vFrontPorch + vSyncLen));

    assign activeWin = (hCnt < coordWidth'(hActive)) &&
                       (vCnt < coordWidth'(vActive));

    // Registered outputs, one cycle behind the counters
    always_ff @(posedge pixelClk) begin
        if (rst) begin
            hSync      <= ~syncActiveLevel;
            vSync      <= ~syncActiveLevel;
            de         <= 1'b0;
            frameStart <= 1'b0;
            x          <= '0;
            y          <= '0;
        end else begin
            hSync      <= hSyncWin ? syncActiveLevel : ~syncActiveLevel;
            vSync      <= vSyncWin ? syncActiveLevel : ~syncActiveLevel;
            de         <= activeWin;
            frameStart <= (hCnt == '0) && (vCnt == '0);
            x          <= hCnt;
            y          <= vCnt;
        end
    end

endmodule

//--- rtl/patternGen.sv
// Test pattern source with one cycle of latency
// patternSel and solidRgb are taken only at frameStart, so a frame never tears
// The frameStart pixel itself already uses the newly taken values
// RGB is forced to zero outside active video
`timescale 1ns/1ps

module patternGen (
    input  logic                            pixelClk,
    input  logic                            rst,
    input  logic [dviPkg::patWidth-1:0]     patternSel,
    input  logic [3*dviPkg::colorWidth-1:0] solidRgb,   // {R, G, B}
    input  logic                            hSync,
    input  logic                            vSync,
    input  logic                            de,
    input  logic                            frameStart,
    input  logic [dviPkg::coordWidth-1:0]   x,
    input  logic [dviPkg::coordWidth-1:0]   y,
    output logic [dviPkg::colorWidth-1:0]   red,
    output logic [dviPkg::colorWidth-1:0]   green,
    output logic [dviPkg::colorWidth-1:0]   blue,
    output logic                            hSyncD,
    output logic                            vSyncD,
    output logic                            deD
);

    import dviPkg::*;

    logic [patWidth-1:0]     modeReg;
    logic [3*colorWidth-1:0] solidReg;
    logic [patWidth-1:0]     modeNow;
    logic [3*colorWidth-1:0] solidNow;
    logic [coordWidth-1:0]   barQuot;
    logic [2:0]              barIdx;
    logic                    checkOn;
    logic [colorWidth-1:0]   rNext;
    logic [colorWidth-1:0]   gNext;
    logic [colorWidth-1:0]   bNext;

    // --------------------------------------------------------------------
    // Per frame settings
    // --------------------------------------------------------------------
    assign modeNow  = frameStart ? patternSel : modeReg;   // Bypass on first pixel
    assign solidNow = frameStart ? solidRgb   : solidReg;

    always_ff @(posedge pixelClk) begin
        if (rst) begin
            modeReg <= patColorBars;
        end else if (frameStart) begin
            modeReg <= patternSel;
        end
    end

    always_ff @(posedge pixelClk) begin
        if (frameStart) begin
            solidReg <= solidRgb;
        end
    end

    // --------------------------------------------------------------------
    // Colour per pixel
    // --------------------------------------------------------------------
    assign barQuot = x / coordWidth'(barWidth);
    assign barIdx  = barQuot[2:0];                           // 0 to 7 across the line
    assign checkOn = x[checkerShift] ^ y[checkerShift];

    always_comb begin
        rNext = '0;
        gNext = '0;
        bNext = '0;
        case (modeNow)
            patColorBars: begin
                // White, yellow, cyan, green, magenta, red, blue, black
                rNext = {colorWidth{~barIdx[1]}};
                gNext = {colorWidth{~barIdx[2]}};
                bNext = {colorWidth{~barIdx[0]}};
            end
            patGradient: begin
                rNext = x[colorWidth-1:0];
                gNext = y[colorWidth-1:0];
                bNext = x[colorWidth-1:0] ^ y[colorWidth-1:0];
            end
            patChecker: begin
                rNext = {colorWidth{checkOn}};
                gNext = {colorWidth{checkOn}};
                bNext = {colorWidth{checkOn}};
            end
            patSolid: begin
                {rNext, gNext, bNext} = solidNow;
            end
            default: ;
        endcase
        if (!de) begin
            rNext = '0;                                      // Blanking
            gNext = '0;
            bNext = '0;
        end
    end

    // Colour registers carry no reset
    always_ff @(posedge pixelClk) begin
        red   <= rNext;
        green <= gNext;
        blue  <= bNext;
    end

    // Controls delayed to match colour
    always_ff @(posedge pixelClk) begin
        if (rst) begin
            hSyncD <= ~syncActiveLevel;
            vSyncD <= ~syncActiveLevel;
            deD    <= 1'b0;
        end else begin
            hSyncD <= hSync;
            vSyncD <= vSync;
            deD    <= de;
        end
    end

endmodule

//--- rtl/tmdsEncoder/tmdsEncoder.sv
// DVI 1.0 TMDS channel encoder, one cycle of latency
// Running disparity is kept in a 5-bit signed counter
// Blanking sends the control token for ctrl and clears the disparity
// Under reset the symbol is tokenC00 with zero disparity
`timescale 1ns/1ps

module tmdsEncoder (
    input  logic                          pixelClk,
    input  logic                          rst,
    input  logic [dviPkg::colorWidth-1:0] data,
    input  logic [1:0]                    ctrl,    // {c1, c0}
    input  logic                          de,
    output logic [dviPkg::tmdsWidth-1:0]  symbol
);

    import dviPkg::*;

    logic [3:0]            onesData;
    logic                  useXnor;
    logic [8:0]            qm;         // Transition minimized word
    logic [3:0]            onesQm;
    logic signed [4:0]     balance;    // Ones minus zeros of qm[7:0]
    logic signed [4:0]     qmBit2;     // 2 * qm[8]
    logic signed [4:0]     qmInv2;     // 2 * ~qm[8]
    logic signed [4:0]     disp;
    logic signed [4:0]     dispNext;
    logic [tmdsWidth-1:0]  dataSym;
    logic [tmdsWidth-1:0]  ctrlSym;

    // --------------------------------------------------------------------
    // Stage 1 of the algorithm, transition minimizing
    // --------------------------------------------------------------------
    always_comb begin
        onesData = '0;
        for (int i = 0; i < colorWidth; i++) begin
            onesData = onesData + {3'b000, data[i]};
        end
    end

    assign useXnor = (onesData > 4'd4) || ((onesData == 4'd4) && !data[0]);

    always_comb begin
        qm[0] = data[0];
        for (int i = 1; i < colorWidth; i++) begin
            qm[i] = useXnor ? ~(qm[i-1] ^ data[i]) : (qm[i-1] ^ data[i]);
        end
        qm[8] = ~useXnor;                                  // 1 marks XOR chaining
    end

    always_comb begin
        onesQm = '0;
        for (int i = 0; i < colorWidth; i++) begin
            onesQm = onesQm + {3'b000, qm[i]};
        end
    end

    assign balance = 5'($signed({1'b0, onesQm, 1'b0}) - 6'sd8);
    assign qmBit2  = $signed({3'b000, qm[8], 1'b0});
    assign qmInv2  = $signed({3'b000, ~qm[8], 1'b0});

    // --------------------------------------------------------------------
    // Stage 2, DC balance
    // --------------------------------------------------------------------
    always_comb begin
        if ((disp == 5'sd0) || (balance == 5'sd0)) begin
            // No bias either way, inversion follows qm[8]
            if (qm[8]) begin
                dataSym  = {2'b01, qm[7:0]};
                dispNext = disp + balance;
            end else begin
                dataSym  = {2'b10, ~qm[7:0]};
                dispNext = disp - balance;
            end
        end else if (((disp > 5'sd0) && (balance > 5'sd0)) ||
                     ((disp < 5'sd0) && (balance < 5'sd0))) begin
            dataSym  = {1'b1, qm[8], ~qm[7:0]};            // Invert to pull back
            dispNext = disp + qmBit2 - balance;
        end else begin
            dataSym  = {1'b0, qm[8], qm[7:0]};
            dispNext = disp - qmInv2 + balance;
        end
    end

    always_comb begin
        case (ctrl)
            2'b00:   ctrlSym = tokenC00;
            2'b01:   ctrlSym = tokenC01;
            2'b10:   ctrlSym = tokenC10;
            default: ctrlSym = tokenC11;
        endcase
    end

    always_ff @(posedge pixelClk) begin
        if (rst) begin
            symbol <= tokenC00;
            disp   <= '0;
        end else if (de) begin
            symbol <= dataSym;
            disp   <= dispNext;
        end else begin
            symbol <= ctrlSym;
            disp   <= '0;                                  // Restart balance each line
        end
    end

endmodule

//--- rtl/dviTop.sv
// DVI 640x480 test pattern pipeline in the pixel clock domain
// Clock manager sits outside, pixelClk and its lock level come in on ports
// Two cycles from a raster position to its symbols on the outputs
// Symbols are 10-bit parallel, serialization is left to the board level
`timescale 1ns/1ps

module dviTop (
    input  logic                            pixelClk,
    input  logic                            rst,
    input  logic                            mmcmLocked,
    input  logic [dviPkg::patWidth-1:0]     patternSel,
    input  logic [3*dviPkg::colorWidth-1:0] solidRgb,
    output logic                            videoRst,
    output logic [dviPkg::tmdsWidth-1:0]    tmdsBlue,
    output logic [dviPkg::tmdsWidth-1:0]    tmdsGreen,
    output logic [dviPkg::tmdsWidth-1:0]    tmdsRed
);

    import dviPkg::*;

    logic                  hSync;
    logic                  vSync;
    logic                  de;
    logic                  frameStart;
    logic [coordWidth-1:0] x;
    logic [coordWidth-1:0] y;
    logic [colorWidth-1:0] red;
    logic [colorWidth-1:0] green;
    logic [colorWidth-1:0] blue;
    logic                  hSyncD;
    logic                  vSyncD;
    logic                  deD;

    // --------------------------------------------------------------------
    // Reset and raster
    // --------------------------------------------------------------------
    resetSync uResetSync (
        .pixelClk (pixelClk),
        .rst      (rst),
        .locked   (mmcmLocked),
        .videoRst (videoRst)
    );

    videoTiming uVideoTiming (
        .pixelClk   (pixelClk),
        .rst        (videoRst),
        .hSync      (hSync),
        .vSync      (vSync),
        .de         (de),
        .frameStart (frameStart),
        .x          (x),
        .y          (y)
    );

    patternGen uPatternGen (
        .pixelClk   (pixelClk),
        .rst        (videoRst),
        .patternSel (patternSel),
        .solidRgb   (solidRgb),
        .hSync      (hSync),
        .vSync      (vSync),
        .de         (de),
        .frameStart (frameStart),
        .x          (x),
        .y          (y),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .hSyncD     (hSyncD),
        .vSyncD     (vSyncD),
        .deD        (deD)
    );

    // --------------------------------------------------------------------
    // TMDS channels, syncs ride on blue only
    // --------------------------------------------------------------------
    tmdsEncoder encBlue (
        .pixelClk (pixelClk), .rst (videoRst),
        .data (blue), .ctrl ({vSyncD, hSyncD}), .de (deD), .symbol (tmdsBlue)
    );

    tmdsEncoder encGreen (
        .pixelClk (pixelClk), .rst (videoRst),
        .data (green), .ctrl (2'b00), .de (deD), .symbol (tmdsGreen)
    );

    tmdsEncoder encRed (
        .pixelClk (pixelClk), .rst (videoRst),
        .data (red), .ctrl (2'b00), .de (deD), .symbol (tmdsRed)
    );

endmodule

//--- sim/dviTop_chk.sv
// Concurrent checks on dviTop, attached by bind
// Sync polarity comes from the package
// Lock is sampled raw, so the check allows three edges of synchronizer delay
`timescale 1ns/1ps

module dviTopChk (
    input logic                         pixelClk,
    input logic                         mmcmLocked,
    input logic                         videoRst,
    input logic                         hSync,
    input logic                         vSync,
    input logic                         de,
    input logic                         frameStart,
    input logic [dviPkg::tmdsWidth-1:0] tmdsBlue,
    input logic [dviPkg::tmdsWidth-1:0] tmdsGreen,
    input logic [dviPkg::tmdsWidth-1:0] tmdsRed
);

    import dviPkg::*;

    // ----------------------------------------------------------------------
    // Raster
    // ----------------------------------------------------------------------
    deOutsideSync: assert property (@(posedge pixelClk)
        de |-> (hSync != syncActiveLevel) && (vSync != syncActiveLevel))
        else $error("de high during a sync pulse");

    frameStartPulse: assert property (@(posedge pixelClk) frameStart |=> !frameStart)
        else $error("frameStart wider than one cycle");

    // ----------------------------------------------------------------------
    // Reset
    // ----------------------------------------------------------------------
    lockLossReset: assert property (@(posedge pixelClk) !$past(mmcmLocked, 3) |-> videoRst)
        else $error("videoRst low three edges after lock was low");

    resetTokens: assert property (@(posedge pixelClk)
        (videoRst && $past(videoRst)) |->
            (tmdsBlue == tokenC00) && (tmdsGreen == tokenC00) && (tmdsRed == tokenC00))
        else $error("symbol other than tokenC00 while held in reset");

endmodule

bind dviTop dviTopChk chk (
    .pixelClk   (pixelClk),
    .mmcmLocked (mmcmLocked),
    .videoRst   (videoRst),
    .hSync      (hSync),
    .vSync      (vSync),
    .de         (de),
    .frameStart (frameStart),
    .tmdsBlue   (tmdsBlue),
    .tmdsGreen  (tmdsGreen),
    .tmdsRed    (tmdsRed)
);

//--- sim/dviTb.sv
// Self-checking testbench for the DVI pattern pipeline
// Reference model follows the timing rules, the pattern rules and the DVI 1.0 encoder
// Symbols are sampled on the falling edge, inputs driven on the rising edge
// Runs about four frames and a restart after loss of lock, which takes a while
`timescale 1ns/1ps

module dviTb;

    import dviPkg::*;

    localparam int     clkPeriodNs = 8;
    localparam int     runFrames   = 5;                  // Three frames, most of a fourth, restart
    localparam longint marginNs    = 20000;
    localparam longint watchdogNs  = longint'(runFrames) * vTotal * hTotal * clkPeriodNs
                                     + marginNs;
    localparam int     seed        = 32'h7ca3;
    localparam int     chBlue      = 0;
    localparam int     chGreen     = 1;
    localparam int     chRed       = 2;

    logic                    pixelClk;
    logic                    rst;
    logic                    mmcmLocked;
    logic [patWidth-1:0]     patternSel;
    logic [3*colorWidth-1:0] solidRgb;
    logic                    videoRst;
    logic [tmdsWidth-1:0]    tmdsBlue;
    logic [tmdsWidth-1:0]    tmdsGreen;
    logic [tmdsWidth-1:0]    tmdsRed;

    bit                      tracking;                   // Compare process enabled
    int                      pos;                        // Raster position of current symbols
    int                      dispRef [3];                // Model disparity per channel
    logic [patWidth-1:0]     modeRef;                    // Pattern latched at frame start
    logic [3*colorWidth-1:0] solidRef;

    dviTop UUT (
        .pixelClk   (pixelClk),
        .rst        (rst),
        .mmcmLocked (mmcmLocked),
        .patternSel (patternSel),
        .solidRgb   (solidRgb),
        .videoRst   (videoRst),
        .tmdsBlue   (tmdsBlue),
        .tmdsGreen  (tmdsGreen),
        .tmdsRed    (tmdsRed)
    );

    always #(clkPeriodNs / 2) pixelClk = ~pixelClk;

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic logic [23:0] refPixel(input logic [patWidth-1:0] mode, input int xPos,
                                             input int yPos, input logic [23:0] solid);
        logic [23:0] barColor [8];
        logic [7:0]  gx;
        logic [7:0]  gy;
        barColor = '{24'hFFFFFF, 24'hFFFF00, 24'h00FFFF, 24'h00FF00,
                     24'hFF00FF, 24'hFF0000, 24'h0000FF, 24'h000000};
        gx = 8'(xPos);
        gy = 8'(yPos);
        case (mode)
            patColorBars: return barColor[xPos / barWidth];
            patGradient:  return {gx, gy, gx ^ gy};
            patChecker:   return (((xPos >> checkerShift) & 1) != ((yPos >> checkerShift) & 1))
                                 ? 24'hFFFFFF : 24'h000000;
            default:      return solid;
        endcase
    endfunction

    // DVI 1.0 data encoding that updates dispRef of the channel
    function automatic logic [9:0] refEncode(input int ch, input logic [7:0] d);
        int         n1d;
        int         n1q;
        int         n0q;
        int         i;
        bit         xnorMode;
        logic [8:0] q;
        logic [9:0] s;
        n1d      = $countones(d);
        xnorMode = (n1d > 4) || ((n1d == 4) && (d[0] == 1'b0));
        q[0]     = d[0];
        for (i = 1; i < 8; i++) begin
            q[i] = xnorMode ? ~(q[i-1] ^ d[i]) : (q[i-1] ^ d[i]);
        end
        q[8] = !xnorMode;
        n1q  = $countones(q[7:0]);
        n0q  = 8 - n1q;
        if ((dispRef[ch] == 0) || (n1q == n0q)) begin
            s = {~q[8], q[8], q[8] ? q[7:0] : ~q[7:0]};
            dispRef[ch] += q[8] ? (n1q - n0q) : (n0q - n1q);
        end else if (((dispRef[ch] > 0) && (n1q > n0q)) ||
                     ((dispRef[ch] < 0) && (n0q > n1q))) begin
            s = {1'b1, q[8], ~q[7:0]};                   // Invert to reduce the bias
            dispRef[ch] += 2 * int'(q[8]) + n0q - n1q;
        end else begin
            s = {1'b0, q[8], q[7:0]};
            dispRef[ch] += n1q - n0q - 2 * int'(!q[8]);
        end
        return s;
    endfunction

    function automatic logic [tmdsWidth-1:0] refToken(input logic c1, input logic c0);
        case ({c1, c0})
            2'b00:   return tokenC00;
            2'b01:   return tokenC01;
            2'b10:   return tokenC10;
            default: return tokenC11;
        endcase
    endfunction

    function automatic string modeName(input logic [patWidth-1:0] mode);
        case (mode)
            patColorBars: return "colour bars";
            patGradient:  return "gradient";
            patChecker:   return "checker";
            default:      return "solid";
        endcase
    endfunction

    function automatic int framePos(input int frame, input int line, input int pixel);
        return frame * hTotal * vTotal + line * hTotal + pixel;
    endfunction

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %0h actual %0h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic checkIdle(input string name);
        checkValue({name, " videoRst"}, 32'd1, 32'(videoRst));
        checkValue({name, " blue"}, 32'(tokenC00), 32'(tmdsBlue));
        checkValue({name, " green"}, 32'(tokenC00), 32'(tmdsGreen));
        checkValue({name, " red"}, 32'(tokenC00), 32'(tmdsRed));
    endtask

    // Called right after the edge that drives lock high with rst low
    task automatic expectRelease(input string name);
        repeat (18) begin
            @(negedge pixelClk);
            checkIdle(name);
        end
        @(negedge pixelClk);
        checkValue({name, " videoRst fall"}, 32'd0, 32'(videoRst));
        pos        = -2;                                 // Two fill cycles before pixel (0,0)
        dispRef    = '{0, 0, 0};
        tracking   = 1'b1;
    endtask

    task automatic waitForPos(input int target);
        while (pos < target) begin
            @(posedge pixelClk);
        end
    endtask

    task automatic compareCycle();
        int                   hPos;
        int                   vPos;
        logic                 hs;
        logic                 vs;
        logic [23:0]          rgb;
        logic [tmdsWidth-1:0] expB;
        logic [tmdsWidth-1:0] expG;
        logic [tmdsWidth-1:0] expR;
        string                where;
        expG = tokenC00;
        expR = tokenC00;
        if (pos < 0) begin
            expB  = refToken(~syncActiveLevel, ~syncActiveLevel);   // Pipeline still filling
            where = "pipeline fill";
        end else begin
            hPos = pos % hTotal;
            vPos = (pos / hTotal) % vTotal;
            if ((hPos == 0) && (vPos == 0)) begin
                modeRef  = patternSel;                   // Stimulus changes only mid-frame
                solidRef = solidRgb;
            end
            if ((hPos < hActive) && (vPos < vActive)) begin
                rgb   = refPixel(modeRef, hPos, vPos, solidRef);
                expR  = refEncode(chRed, rgb[23:16]);
                expG  = refEncode(chGreen, rgb[15:8]);
                expB  = refEncode(chBlue, rgb[7:0]);
                where = $sformatf("%s active x=%0d y=%0d", modeName(modeRef), hPos, vPos);
            end else begin
                hs = ((hPos >= hActive + hFrontPorch) &&
                      (hPos < hActive + hFrontPorch + hSyncLen)) ? syncActiveLevel
                                                                 : ~syncActiveLevel;
                vs = ((vPos >= vActive + vFrontPorch) &&
                      (vPos < vActive + vFrontPorch + vSyncLen)) ? syncActiveLevel
                                                                 : ~syncActiveLevel;
                expB    = refToken(vs, hs);
                dispRef = '{0, 0, 0};                    // Balance restarts in blanking
                where   = $sformatf("%s blanking x=%0d y=%0d", modeName(modeRef), hPos, vPos);
            end
        end
        checkValue({where, " blue"}, 32'(expB), 32'(tmdsBlue));
        checkValue({where, " green"}, 32'(expG), 32'(tmdsGreen));
        checkValue({where, " red"}, 32'(expR), 32'(tmdsRed));
    endtask

    // Compare process runs once per falling edge
    always begin
        wait (tracking);
        @(negedge pixelClk);
        if (tracking) begin
            compareCycle();
            pos = pos + 1;
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(seed));
        pixelClk   = 1'b0;
        rst        = 1'b1;
        mmcmLocked = 1'b0;
        patternSel = patColorBars;
        solidRgb   = '0;
        tracking   = 1'b0;
        pos        = 0;
        modeRef    = patColorBars;
        solidRef   = '0;
        dispRef    = '{0, 0, 0};

        repeat (8) @(posedge pixelClk);
        rst <= 1'b0;
        repeat (3) begin
            @(negedge pixelClk);
            checkIdle("reset hold");
            @(posedge pixelClk);
        end
        mmcmLocked <= 1'b1;
        expectRelease("reset release");

        // Each switch lands mid-frame and must wait for the next frame start
        waitForPos(framePos(0, 240, 320));
        patternSel <= patGradient;
        solidRgb   <= 24'($urandom());
        waitForPos(framePos(1, 240, 320));
        patternSel <= patChecker;
        waitForPos(framePos(2, 240, 320));
        patternSel <= patSolid;
        solidRgb   <= 24'($urandom());
        waitForPos(framePos(3, 200, 100));
        solidRgb   <= 24'($urandom());           // Held off until the next frame

        // Lock loss mid-line
        waitForPos(framePos(3, 300, 123));
        tracking   = 1'b0;
        mmcmLocked <= 1'b0;
        patternSel <= patGradient;
        repeat (3) @(posedge pixelClk);
        @(negedge pixelClk);
        checkIdle("lock loss");
        repeat (20) begin
            @(negedge pixelClk);
            checkIdle("lock lost");
        end
        @(posedge pixelClk);
        mmcmLocked <= 1'b1;
        expectRelease("relock");

        waitForPos(framePos(0, 60, 0));          // Restart checked from pixel (0,0)
        tracking = 1'b0;
        $display("*** PASSED ***");
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdogNs);
        $display("Timeout: run did not finish within %0d ns", watchdogNs);
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- sources.f
common/dviPkg.sv
rtl/resetSync.sv
rtl/videoTiming/videoTiming.sv
rtl/patternGen.sv
rtl/tmdsEncoder/tmdsEncoder.sv
rtl/dviTop.sv
sim/dviTop_chk.sv
sim/dviTb.sv

//--- Makefile
# Verilator flow for the DVI pattern pipeline
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TB_TOP     ?= dviTb
RTL_TOP    ?= dviTop
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= *** PASSED ***
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint lint-rtl sim clean

all: sim

lint: lint-rtl
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

lint-rtl:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		$(filter-out sim/%,$(SOURCES))

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Result is taken from the log, not from the simulator exit status
sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(PASS_TEXT)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
